//--- Bender.yml
package:
  name: eth_mac_fifo

export_include_dirs:
  - .

sources:
  - eth_mac_pkg.sv
  - mac_stream_if.sv
  - frame_fifo.sv
  - gmii_tx_mac.sv
  - gmii_rx_mac.sv
  - eth_mac_fifo.sv
  - target: test
    files:
      - tb_eth_mac_fifo.sv

//--- all.f
+incdir+.
eth_mac_pkg.sv
mac_stream_if.sv
frame_fifo.sv
gmii_tx_mac.sv
gmii_rx_mac.sv
eth_mac_fifo.sv
tb_eth_mac_fifo.sv

//--- eth_mac_fifo.sv
// Gigabit Ethernet MAC with store-and-forward frame FIFOs on transmit and receive.
`timescale 1ns/1ns

module eth_mac_fifo (
    input  logic        logic_clk,
    input  logic        logic_rst,

    // Host transmit stream.
    input  logic [7:0]  s_tx_data,
    input  logic        s_tx_valid,
    input  logic        s_tx_last,
    input  logic        s_tx_user,
    output logic        s_tx_ready,

    // Host receive stream.
    output logic [7:0]  m_rx_data,
    output logic        m_rx_valid,
    output logic        m_rx_last,
    output logic        m_rx_user,
    input  logic        m_rx_ready,

    // GMII.
    input  logic [7:0]  gmii_rxd,
    input  logic        gmii_rx_dv,
    input  logic        gmii_rx_er,
    output logic [7:0]  gmii_txd,
    output logic        gmii_tx_en,
    output logic        gmii_tx_er,

    // Status pulses.
    output logic        tx_fifo_overflow,
    output logic        tx_fifo_bad_frame,
    output logic        tx_fifo_good_frame,
    output logic        rx_error_bad_frame,
    output logic        rx_error_bad_fcs,
    output logic        rx_fifo_overflow,
    output logic        rx_fifo_bad_frame,
    output logic        rx_fifo_good_frame,

    // Configuration.
    input  logic [7:0]  cfg_tx_ifg,
    input  logic        cfg_tx_enable,
    input  logic [15:0] cfg_rx_max_pkt_len,
    input  logic        cfg_rx_enable
);

    eth_mac_pkg::fifo_status_t tx_status;
    eth_mac_pkg::fifo_status_t rx_status;

    mac_stream_if host_tx ();
    mac_stream_if host_rx ();
    mac_stream_if tx_stream ();
    mac_stream_if rx_stream ();

    // ************************************************************
    // Host ports onto the FIFO streams.
    // ************************************************************
    assign host_tx.valid = s_tx_valid;
    assign host_tx.beat  = '{data: s_tx_data, last: s_tx_last, user: s_tx_user};
    assign s_tx_ready    = host_tx.ready;

    assign m_rx_valid    = host_rx.valid;
    assign m_rx_data     = host_rx.beat.data;
    assign m_rx_last     = host_rx.beat.last;
    assign m_rx_user     = host_rx.beat.user;
    assign host_rx.ready = m_rx_ready;

    assign tx_fifo_overflow   = tx_status.overflow;
    assign tx_fifo_bad_frame  = tx_status.bad_frame;
    assign tx_fifo_good_frame = tx_status.good_frame;
    assign rx_fifo_overflow   = rx_status.overflow;
    assign rx_fifo_bad_frame  = rx_status.bad_frame;
    assign rx_fifo_good_frame = rx_status.good_frame;

    // ************************************************************
    // Transmit path.
    // ************************************************************
    frame_fifo tx_fifo (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .s         (host_tx),
        .m         (tx_stream),
        .status    (tx_status)
    );

    gmii_tx_mac tx_mac (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .s             (tx_stream),
        .gmii_txd      (gmii_txd),
        .gmii_tx_en    (gmii_tx_en),
        .gmii_tx_er    (gmii_tx_er),
        .cfg_tx_ifg    (cfg_tx_ifg),
        .cfg_tx_enable (cfg_tx_enable)
    );

    // ************************************************************
    // Receive path.
    // ************************************************************
    gmii_rx_mac rx_mac (
        .logic_clk          (logic_clk),
        .logic_rst          (logic_rst),
        .gmii_rxd           (gmii_rxd),
        .gmii_rx_dv         (gmii_rx_dv),
        .gmii_rx_er         (gmii_rx_er),
        .m                  (rx_stream),
        .cfg_rx_max_pkt_len (cfg_rx_max_pkt_len),
        .cfg_rx_enable      (cfg_rx_enable),
        .error_bad_frame    (rx_error_bad_frame),
        .error_bad_fcs      (rx_error_bad_fcs)
    );

    frame_fifo rx_fifo (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .s         (rx_stream),
        .m         (host_rx),
        .status    (rx_status)
    );

endmodule

//--- eth_mac_pkg.sv
// Ethernet MAC shared types and the byte-wise CRC-32 step.
package eth_mac_pkg;

    // One byte of a frame stream. User set on the last beat marks a bad frame.
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } mac_beat_t;

    // Single-cycle FIFO status pulses.
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } fifo_status_t;

    // Reflected CRC-32, polynomial 0xEDB88320, one byte per call.
    function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
        end
        return c;
    endfunction

endpackage

//--- eth_mac_settings.svh
// Ethernet MAC sizing constants shared by the FIFOs, the MACs and the testbench.
`ifndef ETH_MAC_SETTINGS_SVH
`define ETH_MAC_SETTINGS_SVH

// ************************************************************
// FIFO storage.
// ************************************************************
`define ETH_FIFO_DEPTH 2048
`define ETH_FIFO_ADDR_W 11

// ************************************************************
// Frame format.
// ************************************************************
`define ETH_MIN_FRAME_LEN 64   // Includes the FCS.
`define ETH_PREAMBLE_LEN 7     // 0x55 bytes before the SFD.

`endif

//--- frame_fifo.sv
// Store-and-forward frame FIFO that commits good frames and drops bad or oversized ones.
`timescale 1ns/1ns
`include "eth_mac_settings.svh"

module frame_fifo (
    input  logic                      logic_clk,
    input  logic                      logic_rst,
    mac_stream_if.snk                 s,
    mac_stream_if.src                 m,
    output eth_mac_pkg::fifo_status_t status
);

    localparam int AW = `ETH_FIFO_ADDR_W;

    eth_mac_pkg::mac_beat_t mem [`ETH_FIFO_DEPTH];

    logic [AW:0] wr_ptr;      // Runs ahead of the commit point inside a frame.
    logic [AW:0] commit_ptr;  // End of the last good frame.
    logic [AW:0] rd_ptr;
    logic        drop;        // Discarding the rest of an overflowing frame.
    logic        run;         // Low until the first cycle after reset.
    logic        full;
    logic        wr_en;

    // ************************************************************
    // Flags and handshakes.
    // ************************************************************
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign s.ready = run && (!full || drop);
    assign wr_en   = s.valid && s.ready && !drop;

    // Show-ahead read, only committed frames are visible.
    assign m.valid = (rd_ptr != commit_ptr);
    assign m.beat  = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= s.beat;
        end
    end

    // ************************************************************
    // Pointer control.
    // ************************************************************
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            drop       <= 1'b0;
            run        <= 1'b0;
            status     <= '0;
        end else begin
            run    <= 1'b1;
            status <= '0;

            if (m.valid && m.ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (run && s.valid && !s.ready) begin
                // No room left, throw away what was written of this frame.
                status.overflow <= 1'b1;
                wr_ptr          <= commit_ptr;
                drop            <= !s.beat.last;
            end else if (s.valid && drop) begin
                drop <= !s.beat.last;                  // Discard up to the last beat.
            end else if (wr_en) begin
                if (s.beat.last && s.beat.user) begin
                    wr_ptr           <= commit_ptr;    // Roll back.
                    status.bad_frame <= 1'b1;
                end else if (s.beat.last) begin
                    wr_ptr            <= wr_ptr + 1'b1;
                    commit_ptr        <= wr_ptr + 1'b1;
                    status.good_frame <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

endmodule

//--- gmii_rx_mac.sv
// GMII receive MAC that strips preamble and FCS and flags bad frames.
`timescale 1ns/1ns
`include "eth_mac_settings.svh"

module gmii_rx_mac (
    input  logic        logic_clk,
    input  logic        logic_rst,
    input  logic [7:0]  gmii_rxd,
    input  logic        gmii_rx_dv,
    input  logic        gmii_rx_er,
    mac_stream_if.src   m,
    input  logic [15:0] cfg_rx_max_pkt_len,
    input  logic        cfg_rx_enable,
    output logic        error_bad_frame,
    output logic        error_bad_fcs
);

    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

    typedef enum logic [1:0] {IDLE, PRE, DATA, WAIT} state_t;

    state_t      state;
    logic [3:0]  pre_cnt;
    logic [15:0] cnt;        // Bytes after the SFD, FCS included.
    logic [31:0] crc;
    logic        rx_err;
    logic        fcs_bad;
    logic        len_bad;
    logic [7:0]  dly [5];    // Four FCS stages plus the held payload byte.

    assign fcs_bad = (crc != CRC_RESIDUE);
    assign len_bad = (cnt > cfg_rx_max_pkt_len);

    always_ff @(posedge logic_clk) begin
        if (state == DATA && gmii_rx_dv) begin
            dly[0] <= gmii_rxd;
            for (int i = 1; i < 5; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state           <= IDLE;
            pre_cnt         <= '0;
            cnt             <= '0;
            crc             <= '1;
            rx_err          <= 1'b0;
            m.valid         <= 1'b0;
            m.beat          <= '0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
        end else begin
            m.valid         <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
            case (state)
                IDLE: begin
                    pre_cnt <= 4'd1;
                    if (gmii_rx_dv && cfg_rx_enable) begin
                        state <= (gmii_rxd == 8'h55) ? PRE : WAIT;
                    end
                end
                PRE: begin
                    crc    <= '1;
                    cnt    <= '0;
                    rx_err <= 1'b0;
                    if (!gmii_rx_dv) begin
                        state <= IDLE;
                    end else if (gmii_rxd == 8'h55) begin
                        if (pre_cnt < `ETH_PREAMBLE_LEN) begin
                            pre_cnt <= pre_cnt + 4'd1;
                        end
                    end else if (gmii_rxd == 8'hD5 && pre_cnt == `ETH_PREAMBLE_LEN) begin
                        state <= DATA;
                    end else begin
                        state <= WAIT;                         // Broken preamble.
                    end
                end
                DATA: begin
                    if (gmii_rx_dv) begin
                        crc    <= eth_mac_pkg::crc32_step(crc, gmii_rxd);
                        rx_err <= rx_err | gmii_rx_er;
                        if (cnt != '1) begin
                            cnt <= cnt + 16'd1;
                        end
                        if (cnt >= 16'd5) begin
                            m.valid <= 1'b1;                   // Oldest byte is payload.
                            m.beat  <= '{data: dly[4], last: 1'b0, user: 1'b0};
                        end
                    end else begin
                        // Frame ended, dly[0..3] hold the FCS.
                        if (cnt >= 16'd5) begin
                            m.valid <= 1'b1;
                            m.beat  <= '{data: dly[4], last: 1'b1,
                                         user: rx_err | len_bad | fcs_bad};
                        end
                        error_bad_frame <= rx_err | len_bad | fcs_bad;
                        error_bad_fcs   <= fcs_bad;
                        state           <= IDLE;
                    end
                end
                WAIT: begin
                    if (!gmii_rx_dv) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- gmii_tx_mac.sv
// GMII transmit MAC adding preamble, padding, FCS and the inter-frame gap.
`timescale 1ns/1ns
`include "eth_mac_settings.svh"

module gmii_tx_mac (
    input  logic       logic_clk,
    input  logic       logic_rst,
    mac_stream_if.snk  s,
    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er,
    input  logic [7:0] cfg_tx_ifg,
    input  logic       cfg_tx_enable
);

    localparam int PAD_LEN = `ETH_MIN_FRAME_LEN - 4;   // Payload bytes before the FCS.

    typedef enum logic [2:0] {IDLE, PREAMBLE, DATA, PAD, FCS, GAP} state_t;

    state_t      state;
    logic [7:0]  cnt;    // Preamble, FCS and gap counter.
    logic [6:0]  len;    // Payload bytes sent, stops at PAD_LEN.
    logic [31:0] crc;

    // The FIFO holds whole frames, so valid stays high through DATA.
    assign s.ready    = (state == DATA);
    assign gmii_tx_er = 1'b0;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= IDLE;
            cnt        <= '0;
            len        <= '0;
            crc        <= '1;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    gmii_tx_en <= 1'b0;
                    if (s.valid && cfg_tx_enable) begin
                        gmii_txd   <= 8'h55;
                        gmii_tx_en <= 1'b1;
                        cnt        <= 8'd1;
                        state      <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    if (cnt < `ETH_PREAMBLE_LEN) begin
                        gmii_txd <= 8'h55;
                        cnt      <= cnt + 8'd1;
                    end else begin
                        gmii_txd <= 8'hD5;                       // SFD.
                        crc      <= '1;
                        len      <= '0;
                        state    <= DATA;
                    end
                end
                DATA: begin
                    gmii_txd <= s.beat.data;
                    crc      <= eth_mac_pkg::crc32_step(crc, s.beat.data);
                    if (len < PAD_LEN) begin
                        len <= len + 7'd1;
                    end
                    if (s.beat.last) begin
                        cnt   <= '0;
                        state <= (len < PAD_LEN - 1) ? PAD : FCS;
                    end
                end
                PAD: begin
                    gmii_txd <= 8'h00;
                    crc      <= eth_mac_pkg::crc32_step(crc, 8'h00);
                    len      <= len + 7'd1;
                    if (len == PAD_LEN - 1) begin
                        state <= FCS;
                    end
                end
                FCS: begin
                    gmii_txd <= ~crc[8*cnt[1:0] +: 8];             // Low byte first.
                    cnt      <= cnt + 8'd1;
                    if (cnt == 8'd3) begin
                        cnt   <= '0;
                        state <= GAP;
                    end
                end
                GAP: begin
                    gmii_tx_en <= 1'b0;
                    cnt        <= cnt + 8'd1;
                    if (cnt + 8'd1 >= cfg_tx_ifg) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- mac_stream_if.sv
// Byte stream with valid/ready handshake between the FIFOs and the MACs.
`timescale 1ns/1ns

interface mac_stream_if;

    logic                   valid;
    logic                   ready;
    eth_mac_pkg::mac_beat_t beat;   // Held stable while valid waits on ready.

    modport src (
        output valid,
        output beat,
        input  ready
    );

    modport snk (
        input  valid,
        input  beat,
        output ready
    );

endinterface

//--- tb_eth_mac_fifo.sv
// Directed testbench for the Ethernet MAC with frame FIFOs, run through a GMII loopback.
`timescale 1ns/1ns
`include "eth_mac_settings.svh"

module tb_eth_mac_fifo;

    localparam int MIN_PAYLOAD = `ETH_MIN_FRAME_LEN - 4;
    localparam int MAX_LEN     = 300;                       // Longest random frame.
    localparam int BIG_LEN     = `ETH_FIFO_DEPTH + 52;      // Does not fit either FIFO.
    // Each frame needs its length plus about a hundred cycles of framing, gap and delivery.
    localparam int CYCLE_LIMIT = 2 * (2 * BIG_LEN + 8 * (MAX_LEN + 100));

    logic        logic_clk = 1'b0;
    logic        logic_rst;
    logic [7:0]  s_tx_data, m_rx_data, gmii_rxd, gmii_txd, cfg_tx_ifg;
    logic        s_tx_valid, s_tx_last, s_tx_user, s_tx_ready;
    logic        m_rx_valid, m_rx_last, m_rx_user, m_rx_ready;
    logic        gmii_rx_dv, gmii_rx_er, gmii_tx_en, gmii_tx_er;
    logic        tx_fifo_overflow, tx_fifo_bad_frame, tx_fifo_good_frame;
    logic        rx_error_bad_frame, rx_error_bad_fcs;
    logic        rx_fifo_overflow, rx_fifo_bad_frame, rx_fifo_good_frame;
    logic        cfg_tx_enable, cfg_rx_enable;
    logic [15:0] cfg_rx_max_pkt_len;

    // Direct GMII drive for error injection.
    logic        inj, inj_dv, inj_er;
    logic [7:0]  inj_rxd;

    logic [7:0]  frame_q[$];    // Payload of the frame under test.
    logic [7:0]  wire_q[$];     // Bytes seen on gmii_txd.
    logic [8:0]  exp_q[$];      // Scoreboard of {last, data} for m_rx.
    logic        prev_en = 1'b0;
    int          errors = 0, checks = 0, cycles = 0;
    int          tx_starts = 0, tx_frames = 0, rx_frames = 0, low_cnt = 0, min_gap = 1000;
    int          n_tx_bad = 0, n_rx_good = 0, n_rx_bad = 0, n_rx_ovf = 0;
    int          n_tx_good = 0, n_tx_ovf = 0;
    int          n_bad_frame = 0, n_bad_fcs = 0;

    assign gmii_rxd   = inj ? inj_rxd : gmii_txd;           // Loopback by default.
    assign gmii_rx_dv = inj ? inj_dv : gmii_tx_en;
    assign gmii_rx_er = inj ? inj_er : gmii_tx_er;

    eth_mac_fifo uut (.*);

    always #20 logic_clk = ~logic_clk;

    always @(posedge logic_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ************************************************************
    // Checking helpers.
    // ************************************************************
    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_rx_beat();
        logic [8:0] e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("The receive stream delivered a byte that no frame expects");
        end else begin
            e = exp_q.pop_front();
            compare_value("m_rx_data", m_rx_data, e[7:0]);
            compare_value("m_rx_last", m_rx_last, e[8]);
            if (m_rx_last) begin
                compare_value("m_rx_user", m_rx_user, 0);
                rx_frames++;
            end
        end
    endtask

    // Outputs are sampled at the falling edge, half a cycle away from any change.
    always @(negedge logic_clk) begin
        if (!logic_rst) begin
            n_tx_bad    += tx_fifo_bad_frame;
            n_tx_good   += tx_fifo_good_frame;
            n_tx_ovf    += tx_fifo_overflow;
            n_rx_good   += rx_fifo_good_frame;
            n_rx_bad    += rx_fifo_bad_frame;
            n_rx_ovf    += rx_fifo_overflow;
            n_bad_frame += rx_error_bad_frame;
            n_bad_fcs   += rx_error_bad_fcs;
            compare_value("gmii_tx_er", gmii_tx_er, 0);
            if (gmii_tx_en) begin
                wire_q.push_back(gmii_txd);
                if (!prev_en) begin
                    tx_starts++;
                    if (tx_frames > 0 && low_cnt < min_gap) begin
                        min_gap = low_cnt;                  // Idle cycles since last frame.
                    end
                end
                low_cnt = 0;
            end else begin
                if (prev_en) begin
                    tx_frames++;
                end
                low_cnt++;
            end
            prev_en = gmii_tx_en;
            if (m_rx_valid && m_rx_ready) begin
                check_rx_beat();
            end
        end
    end

    // ************************************************************
    // Stimulus helpers.
    // ************************************************************
    task automatic next_cycle();
        @(posedge logic_clk);
        #1;
    endtask

    task automatic make_frame(input int len);
        logic [7:0] b;
        frame_q.delete();
        repeat (len) begin
            b = $urandom;
            frame_q.push_back(b);
        end
    endtask

    // Padded payload as the host should receive it.
    task automatic expect_rx();
        int n;
        n = (frame_q.size() < MIN_PAYLOAD) ? MIN_PAYLOAD : frame_q.size();
        for (int i = 0; i < n; i++) begin
            exp_q.push_back({i == n - 1, (i < frame_q.size()) ? frame_q[i] : 8'h00});
        end
    endtask

    task automatic send_tx(input logic bad);
        foreach (frame_q[i]) begin
            s_tx_data  = frame_q[i];
            s_tx_valid = 1'b1;
            s_tx_last  = (i == frame_q.size() - 1);
            s_tx_user  = bad && s_tx_last;
            @(negedge logic_clk);
            while (!s_tx_ready) @(negedge logic_clk);
            next_cycle();
        end
        s_tx_valid = 1'b0;
        s_tx_last  = 1'b0;
        s_tx_user  = 1'b0;
    endtask

    task automatic check_wire();
        logic [31:0] crc;
        logic [7:0]  b;
        int          n;
        n = (frame_q.size() < MIN_PAYLOAD) ? MIN_PAYLOAD : frame_q.size();
        compare_value("gmii frame length", wire_q.size(), `ETH_PREAMBLE_LEN + 1 + n + 4);
        if (wire_q.size() == `ETH_PREAMBLE_LEN + 1 + n + 4) begin
            for (int i = 0; i < `ETH_PREAMBLE_LEN; i++) begin
                compare_value("gmii_txd preamble", wire_q.pop_front(), 8'h55);
            end
            compare_value("gmii_txd sfd", wire_q.pop_front(), 8'hD5);
            crc = '1;
            for (int i = 0; i < n; i++) begin
                b   = (i < frame_q.size()) ? frame_q[i] : 8'h00;
                crc = eth_mac_pkg::crc32_step(crc, b);
                compare_value("gmii_txd payload", wire_q.pop_front(), b);
            end
            for (int i = 0; i < 4; i++) begin
                b = ~crc[8*i +: 8];                         // FCS, low byte first.
                compare_value("gmii_txd fcs", wire_q.pop_front(), b);
            end
        end
    endtask

    task automatic inject_frame(input logic bad_fcs, input logic rx_er);
        logic [7:0]  line[$];
        logic [31:0] crc;
        crc = '1;
        repeat (`ETH_PREAMBLE_LEN) line.push_back(8'h55);
        line.push_back(8'hD5);
        foreach (frame_q[i]) begin
            line.push_back(frame_q[i]);
            crc = eth_mac_pkg::crc32_step(crc, frame_q[i]);
        end
        for (int i = 0; i < 4; i++) begin
            line.push_back(~crc[8*i +: 8] ^ {8{bad_fcs && i == 3}});
        end
        inj = 1'b1;
        foreach (line[i]) begin
            inj_rxd = line[i];
            inj_dv  = 1'b1;
            inj_er  = rx_er && (i == 20);                   // Inside the payload.
            next_cycle();
        end
        inj_dv = 1'b0;
        inj_er = 1'b0;
        next_cycle();
        inj = 1'b0;
    endtask

    // ************************************************************
    // Tests.
    // ************************************************************
    task automatic test_loopback();
        int good, tx0, rx0, tx_good;
        good    = n_rx_good;
        tx0     = tx_frames;
        rx0     = rx_frames;
        tx_good = n_tx_good;
        make_frame(20);
        wire_q.delete();
        expect_rx();
        send_tx(1'b0);
        while (tx_frames < tx0 + 1 || rx_frames < rx0 + 1) next_cycle();
        check_wire();
        compare_value("tx_fifo_good_frame pulses", n_tx_good - tx_good, 1);
        compare_value("rx_fifo_good_frame pulses", n_rx_good - good, 1);
    endtask

    task automatic test_tx_bad();
        int bad, starts, tx_good;
        bad     = n_tx_bad;
        starts  = tx_starts;
        tx_good = n_tx_good;
        make_frame(30);
        send_tx(1'b1);
        while (n_tx_bad < bad + 1) next_cycle();
        repeat (20) next_cycle();                           // Room for a wrong start.
        compare_value("tx_fifo_bad_frame pulses", n_tx_bad - bad, 1);
        compare_value("tx_fifo_good_frame pulses", n_tx_good - tx_good, 0);
        compare_value("gmii_tx_en rises", tx_starts - starts, 0);
    endtask

    // A frame larger than the transmit FIFO is discarded and never reaches GMII.
    task automatic test_tx_overflow();
        int ovf, starts, tx_good;
        ovf     = n_tx_ovf;
        starts  = tx_starts;
        tx_good = n_tx_good;
        make_frame(BIG_LEN);
        send_tx(1'b0);
        repeat (20) next_cycle();
        compare_value("tx_fifo_overflow pulses", n_tx_ovf - ovf, 1);
        compare_value("tx_fifo_good_frame pulses", n_tx_good - tx_good, 0);
        compare_value("gmii_tx_en rises", tx_starts - starts, 0);
    endtask

    task automatic test_rx_errors();
        int bad, frm, fcs;
        bad = n_rx_bad;
        frm = n_bad_frame;
        fcs = n_bad_fcs;
        make_frame(40);
        inject_frame(1'b1, 1'b0);
        while (n_rx_bad < bad + 1) next_cycle();
        compare_value("rx_error_bad_fcs pulses", n_bad_fcs - fcs, 1);
        inject_frame(1'b0, 1'b1);
        while (n_rx_bad < bad + 2) next_cycle();
        compare_value("rx_error_bad_fcs pulses", n_bad_fcs - fcs, 1);
        compare_value("rx_error_bad_frame pulses", n_bad_frame - frm, 2);
        compare_value("rx_fifo_bad_frame pulses", n_rx_bad - bad, 2);
    endtask

    task automatic test_ifg();
        int rx0;
        rx0     = rx_frames;
        min_gap = 1000;
        make_frame(20);
        expect_rx();
        send_tx(1'b0);
        make_frame(40);
        expect_rx();
        send_tx(1'b0);
        while (rx_frames < rx0 + 2) next_cycle();
        // A short gap shows up as its measured length.
        compare_value("gmii_tx_en gap", (min_gap < cfg_tx_ifg) ? min_gap : cfg_tx_ifg,
                      cfg_tx_ifg);
    endtask

    task automatic test_backpressure();
        int good, ovf, rx0;
        good       = n_rx_good;
        ovf        = n_rx_ovf;
        rx0        = rx_frames;
        m_rx_ready = 1'b0;
        for (int k = 0; k < 3; k++) begin
            make_frame($urandom_range(1, MAX_LEN));
            expect_rx();
            send_tx(1'b0);
        end
        while (n_rx_good < good + 3) next_cycle();
        make_frame(BIG_LEN);
        inject_frame(1'b0, 1'b0);
        repeat (4) next_cycle();
        compare_value("rx_fifo_overflow pulses", n_rx_ovf - ovf, 1);
        compare_value("rx_fifo_good_frame pulses", n_rx_good - good, 3);
        m_rx_ready = 1'b1;
        while (rx_frames < rx0 + 3) next_cycle();
        repeat (4) next_cycle();
        compare_value("undelivered bytes", exp_q.size(), 0);
    endtask

    initial begin
        void'($urandom(96520));
        logic_rst          = 1'b1;
        s_tx_data          = 8'h00;
        s_tx_valid         = 1'b0;
        s_tx_last          = 1'b0;
        s_tx_user          = 1'b0;
        m_rx_ready         = 1'b1;
        inj                = 1'b0;
        inj_rxd            = 8'h00;
        inj_dv             = 1'b0;
        inj_er             = 1'b0;
        cfg_tx_ifg         = 8'd12;
        cfg_tx_enable      = 1'b1;
        cfg_rx_max_pkt_len = 16'd9000;
        cfg_rx_enable      = 1'b1;
        repeat (5) @(posedge logic_clk);
        #1;
        compare_value("s_tx_ready", s_tx_ready, 0);
        compare_value("gmii_tx_en", gmii_tx_en, 0);
        compare_value("m_rx_valid", m_rx_valid, 0);
        logic_rst = 1'b0;
        next_cycle();
        next_cycle();

        test_loopback();
        test_tx_bad();
        test_tx_overflow();
        test_rx_errors();
        test_ifg();
        test_backpressure();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
